// File: hdl/ctrl_pkg.sv
// error, term and gain definitions for the heading controller math
// gains are fixed here, there is no runtime programming path
package ctrl_pkg;

    ////////////////////////////////////////////////////////////
    // error path
    ////////////////////////////////////////////////////////////

    // saturated error, actual minus desired
    localparam int ERR_W = 10;
    localparam logic signed [ERR_W-1:0] ERR_MAX = {1'b0, {(ERR_W-1){1'b1}}};
    localparam logic signed [ERR_W-1:0] ERR_MIN = {1'b1, {(ERR_W-1){1'b0}}};

    // derivative compares against the error this many valid samples back
    localparam int D_DEPTH = 12;

    // clamped derivative difference and its gain
    localparam int D_DIFF_W = 7;
    localparam logic signed [D_DIFF_W-1:0] D_DIFF_MAX = {1'b0, {(D_DIFF_W-1){1'b1}}};
    localparam logic signed [D_DIFF_W-1:0] D_DIFF_MIN = {1'b1, {(D_DIFF_W-1){1'b0}}};
    localparam int D_GAIN = 7;

    ////////////////////////////////////////////////////////////
    // term widths
    ////////////////////////////////////////////////////////////

    localparam int TERM_W = 12;   // integral and derivative
    localparam int P_W = 10;      // proportional

    // integrator clamps instead of wrapping
    localparam int INTEG_W = 16;
    localparam logic signed [INTEG_W-1:0] INTEG_MAX = {1'b0, {(INTEG_W-1){1'b1}}};
    localparam logic signed [INTEG_W-1:0] INTEG_MIN = {1'b1, {(INTEG_W-1){1'b0}}};
    // integrator to iterm scaling
    localparam int I_SHIFT = 4;

    // registered error sample with its strobe
    typedef struct packed {
        logic signed [ERR_W-1:0] value;
        logic                    valid;
    } err_sample_t;

    // proportional and derivative terms handed to the mixer
    typedef struct packed {
        logic signed [P_W-1:0]    pterm;
        logic signed [TERM_W-1:0] dterm;
    } pd_terms_t;

endpackage

// File: hdl/drive_pkg.sv
// motor command definitions for the left and right drive outputs
// commands are signed and clamped, PWM generation is outside this block
package drive_pkg;

    ////////////////////////////////////////////////////////////
    // command range
    ////////////////////////////////////////////////////////////

    // signed motor command, one per wheel
    localparam int CMD_W = 12;
    localparam logic signed [CMD_W-1:0] CMD_MAX = {1'b0, {(CMD_W-1){1'b1}}};
    localparam logic signed [CMD_W-1:0] CMD_MIN = {1'b1, {(CMD_W-1){1'b0}}};

    // mixer accumulates p, i, d and steer at this width
    // wide enough that no intermediate sum can wrap
    localparam int SUM_W = 14;

    ////////////////////////////////////////////////////////////
    // command pair
    ////////////////////////////////////////////////////////////

    // left and right commands travel together
    typedef struct packed {
        logic signed [CMD_W-1:0] lft;
        logic signed [CMD_W-1:0] rght;
    } drive_cmd_t;

endpackage

// File: hdl/pd_math.sv
// error saturation plus proportional and derivative terms, two cycles after vld
// desired and actual are treated as signed 16-bit values
`timescale 1ns/1ns

module pd_math (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  vld,
    input  logic [15:0]           desired,
    input  logic [15:0]           actual,
    output ctrl_pkg::err_sample_t err,
    output ctrl_pkg::pd_terms_t   pd,
    output logic                  pd_vld
);

    // raw difference, one bit wider than the inputs
    logic signed [16:0] diff_raw;
    logic signed [ctrl_pkg::ERR_W-1:0] err_sat;

    // registered error sample
    ctrl_pkg::err_sample_t err_q;

    // history of valid errors, index D_DEPTH-1 is the oldest
    logic signed [ctrl_pkg::ERR_W-1:0] hist [ctrl_pkg::D_DEPTH];

    // derivative difference before and after the clamp
    logic signed [ctrl_pkg::ERR_W:0]      d_diff;
    logic signed [ctrl_pkg::D_DIFF_W-1:0] d_diff_sat;
    logic signed [ctrl_pkg::D_DIFF_W-1:0] d_diff_q;
    logic signed [ctrl_pkg::TERM_W-1:0]   d_diff_ext;

    // proportional term
    logic signed [ctrl_pkg::P_W-1:0] pterm_next;
    logic signed [ctrl_pkg::P_W-1:0] pterm_q;

    ////////////////////////////////////////////////////////////
    // stage 1: error
    ////////////////////////////////////////////////////////////

    // sign extend both readings before subtracting
    assign diff_raw = $signed({actual[15], actual}) - $signed({desired[15], desired});

    // clamp to the 10-bit error range
    assign err_sat = (diff_raw > ctrl_pkg::ERR_MAX) ? ctrl_pkg::ERR_MAX :
                     (diff_raw < ctrl_pkg::ERR_MIN) ? ctrl_pkg::ERR_MIN :
                     $signed(diff_raw[ctrl_pkg::ERR_W-1:0]);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            err_q <= '0;
        end else begin
            err_q.valid <= vld;
            // value only moves on a strobe
            if (vld) begin
                err_q.value <= err_sat;
            end
        end
    end

    assign err = err_q;

    ////////////////////////////////////////////////////////////
    // stage 2: proportional and derivative
    ////////////////////////////////////////////////////////////

    // 5/8 of the error as asr 1 plus asr 3
    assign pterm_next = (err_q.value >>> 1) + (err_q.value >>> 3);

    // current error against the one D_DEPTH valid samples back
    assign d_diff = {err_q.value[ctrl_pkg::ERR_W-1], err_q.value} -
                    {hist[ctrl_pkg::D_DEPTH-1][ctrl_pkg::ERR_W-1], hist[ctrl_pkg::D_DEPTH-1]};

    // clamp to 7 bits before the gain
    assign d_diff_sat = (d_diff > ctrl_pkg::D_DIFF_MAX) ? ctrl_pkg::D_DIFF_MAX :
                        (d_diff < ctrl_pkg::D_DIFF_MIN) ? ctrl_pkg::D_DIFF_MIN :
                        $signed(d_diff[ctrl_pkg::D_DIFF_W-1:0]);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pterm_q  <= '0;
            d_diff_q <= '0;
            pd_vld   <= 1'b0;
        end else begin
            pd_vld <= err_q.valid;
            if (err_q.valid) begin
                pterm_q  <= pterm_next;
                d_diff_q <= d_diff_sat;
            end
        end
    end

    // history advances only on valid samples, zeros until it fills
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < ctrl_pkg::D_DEPTH; i++) begin
                hist[i] <= '0;
            end
        end else if (err_q.valid) begin
            hist[0] <= err_q.value;
            for (int i = 1; i < ctrl_pkg::D_DEPTH; i++) begin
                hist[i] <= hist[i-1];
            end
        end
    end

    // dterm is combinational from the clamped difference
    assign d_diff_ext = ctrl_pkg::TERM_W'(d_diff_q);
    assign pd.dterm   = d_diff_ext * ctrl_pkg::TERM_W'(ctrl_pkg::D_GAIN);
    assign pd.pterm   = pterm_q;

endmodule

// File: hdl/i_math.sv
// saturating integrator for the heading error, iterm follows it combinationally
// pwr_up low holds the integrator at zero and drops incoming samples
`timescale 1ns/1ns

module i_math (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               pwr_up,
    input  ctrl_pkg::err_sample_t              err,
    output logic signed [ctrl_pkg::TERM_W-1:0] iterm
);

    ////////////////////////////////////////////////////////////
    // accumulate
    ////////////////////////////////////////////////////////////

    // integrator state
    logic signed [ctrl_pkg::INTEG_W-1:0] integ;

    // error widened to the integrator width
    logic signed [ctrl_pkg::INTEG_W-1:0] err_ext;

    // one extra bit so overflow is visible before the clamp
    logic signed [ctrl_pkg::INTEG_W:0] integ_sum;

    // clamped next value
    logic signed [ctrl_pkg::INTEG_W-1:0] integ_next;

    // integrator shifted down before truncating to the term width
    logic signed [ctrl_pkg::INTEG_W-1:0] integ_scaled;

    // size cast of a signed value sign extends
    assign err_ext = ctrl_pkg::INTEG_W'(err.value);

    assign integ_sum = {integ[ctrl_pkg::INTEG_W-1], integ} +
                       {err_ext[ctrl_pkg::INTEG_W-1], err_ext};

    // clamp at the signed rails instead of wrapping
    always_comb begin
        if (integ_sum > ctrl_pkg::INTEG_MAX) begin
            integ_next = ctrl_pkg::INTEG_MAX;
        end else if (integ_sum < ctrl_pkg::INTEG_MIN) begin
            integ_next = ctrl_pkg::INTEG_MIN;
        end else begin
            integ_next = integ_sum[ctrl_pkg::INTEG_W-1:0];
        end
    end

    ////////////////////////////////////////////////////////////
    // integrator register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            integ <= '0;
        end else if (!pwr_up) begin
            // held clear while powering up, samples are ignored
            integ <= '0;
        end else if (err.valid) begin
            integ <= integ_next;
        end
    end

    ////////////////////////////////////////////////////////////
    // output scaling
    ////////////////////////////////////////////////////////////

    // 16 bits asr 4 leaves exactly 12 significant bits
    assign integ_scaled = integ >>> ctrl_pkg::I_SHIFT;
    assign iterm        = integ_scaled[ctrl_pkg::TERM_W-1:0];

endmodule

// File: hdl/pid_mix.sv
// mixes p, i and d terms with the steering offset into clamped motor commands
// one cycle after pd_vld, cmd holds between strobes
`timescale 1ns/1ns

module pid_mix (
    input  logic                               clk,
    input  logic                               rst_n,
    input  ctrl_pkg::pd_terms_t                pd,
    input  logic                               pd_vld,
    input  logic signed [ctrl_pkg::TERM_W-1:0] iterm,
    input  logic signed [drive_pkg::CMD_W-1:0] steer,
    output drive_pkg::drive_cmd_t              cmd,
    output logic                               cmd_vld
);

    // each term widened to the mixer width
    logic signed [drive_pkg::SUM_W-1:0] p_ext;
    logic signed [drive_pkg::SUM_W-1:0] i_ext;
    logic signed [drive_pkg::SUM_W-1:0] d_ext;
    logic signed [drive_pkg::SUM_W-1:0] steer_ext;

    // common pid sum and per side totals
    logic signed [drive_pkg::SUM_W-1:0] pid_sum;
    logic signed [drive_pkg::SUM_W-1:0] lft_sum;
    logic signed [drive_pkg::SUM_W-1:0] rght_sum;

    // clamped command pair, not yet registered
    drive_pkg::drive_cmd_t cmd_next;

    // registered output pair
    drive_pkg::drive_cmd_t cmd_q;

    ////////////////////////////////////////////////////////////
    // clamp helper
    ////////////////////////////////////////////////////////////

    // saturate a mixer sum to the command range
    function automatic logic signed [drive_pkg::CMD_W-1:0] sat_cmd(
        input logic signed [drive_pkg::SUM_W-1:0] v
    );
        if (v > drive_pkg::CMD_MAX) begin
            return drive_pkg::CMD_MAX;
        end else if (v < drive_pkg::CMD_MIN) begin
            return drive_pkg::CMD_MIN;
        end
        return v[drive_pkg::CMD_W-1:0];
    endfunction

    ////////////////////////////////////////////////////////////
    // sum
    ////////////////////////////////////////////////////////////

    // sign extend every operand before adding
    assign p_ext     = drive_pkg::SUM_W'(pd.pterm);
    assign i_ext     = drive_pkg::SUM_W'(iterm);
    assign d_ext     = drive_pkg::SUM_W'(pd.dterm);
    assign steer_ext = drive_pkg::SUM_W'(steer);

    assign pid_sum = p_ext + i_ext + d_ext;

    // steer pushes the two sides apart
    assign lft_sum  = pid_sum + steer_ext;
    assign rght_sum = pid_sum - steer_ext;

    // each side clamps on its own
    assign cmd_next.lft  = sat_cmd(lft_sum);
    assign cmd_next.rght = sat_cmd(rght_sum);

    ////////////////////////////////////////////////////////////
    // output register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd_q   <= '0;
            cmd_vld <= 1'b0;
        end else begin
            cmd_vld <= pd_vld;
            // commands only update with a new term pair
            if (pd_vld) begin
                cmd_q <= cmd_next;
            end
        end
    end

    assign cmd = cmd_q;

endmodule

// File: hdl/heading_pid.sv
// heading controller top, vld to cmd_vld is three cycles
// samples may overlap in the pipeline, there is no back-pressure
`timescale 1ns/1ns

module heading_pid (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               vld,
    input  logic [15:0]                        desired,
    input  logic [15:0]                        actual,
    input  logic signed [drive_pkg::CMD_W-1:0] steer,
    input  logic                               pwr_up,
    output drive_pkg::drive_cmd_t              cmd,
    output logic                               cmd_vld
);

    // error sample shared by the p/d and i paths
    ctrl_pkg::err_sample_t err;

    // p and d terms with their strobe
    ctrl_pkg::pd_terms_t pd;
    logic                pd_vld;

    // integral term, valid alongside pd
    logic signed [ctrl_pkg::TERM_W-1:0] iterm;

    // error, proportional and derivative
    pd_math u_pd_math (
        .clk     (clk),
        .rst_n   (rst_n),
        .vld     (vld),
        .desired (desired),
        .actual  (actual),
        .err     (err),
        .pd      (pd),
        .pd_vld  (pd_vld)
    );

    // integral, in parallel on the same error
    i_math u_i_math (
        .clk    (clk),
        .rst_n  (rst_n),
        .pwr_up (pwr_up),
        .err    (err),
        .iterm  (iterm)
    );

    // final sum and motor commands
    pid_mix u_pid_mix (
        .clk     (clk),
        .rst_n   (rst_n),
        .pd      (pd),
        .pd_vld  (pd_vld),
        .iterm   (iterm),
        .steer   (steer),
        .cmd     (cmd),
        .cmd_vld (cmd_vld)
    );

endmodule

// File: bench/heading_pid_asserts.sv
// concurrent checks on strobe timing and command stability, bound into heading_pid
`timescale 1ns/1ns

module heading_pid_asserts (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  vld,
    input logic                  cmd_vld,
    input drive_pkg::drive_cmd_t cmd
);

    // every vld gives a strobe three edges later
    assert property (@(posedge clk) disable iff (!rst_n) vld |-> ##3 cmd_vld)
        else $error("cmd_vld missing three cycles after vld");

    // no strobe without a vld three edges earlier
    assert property (@(posedge clk) disable iff (!rst_n) cmd_vld |-> $past(vld, 3))
        else $error("cmd_vld without a matching vld");

    // cmd only moves together with a strobe
    assert property (@(posedge clk) disable iff (!rst_n) $changed(cmd) |-> cmd_vld)
        else $error("cmd changed while cmd_vld was low");

endmodule

bind heading_pid heading_pid_asserts u_asserts (
    .clk     (clk),
    .rst_n   (rst_n),
    .vld     (vld),
    .cmd_vld (cmd_vld),
    .cmd     (cmd)
);

// File: bench/heading_pid_tb.sv
// self-checking bench for heading_pid, stimulus is random with a fixed seed
// pwr_up only moves while vld has been idle, so a sample sees one pwr_up level
`timescale 1ns/1ns

module heading_pid_tb;

    localparam int RESET_CYCLES = 10;
    localparam int GAP_CYCLES = 9;
    localparam int STIM_CYCLES = 60 + 60 + GAP_CYCLES + 200 + 360 + 100 + GAP_CYCLES
                                 + 100 + GAP_CYCLES + 60 + 10;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + STIM_CYCLES + 20;

    // one sampled input set, kept until its command is due
    typedef struct packed {
        logic [15:0] desired;
        logic [15:0] actual;
        logic        pwr_up;
    } sample_t;

    logic                  clk;
    logic                  rst_n;
    logic                  vld;
    logic [15:0]           desired;
    logic [15:0]           actual;
    logic signed [11:0]    steer;
    logic                  pwr_up;
    drive_pkg::drive_cmd_t cmd;
    logic                  cmd_vld;

    int seed = 32'h978c_e01f;

    // reference model state
    int ref_hist [ctrl_pkg::D_DEPTH];
    int ref_integ;

    // samples waiting for steer, commands waiting for cmd_vld
    sample_t               sample_q [$];
    drive_pkg::drive_cmd_t exp_q [$];
    // vld seen at the last three rising edges, bit 2 the oldest
    logic [2:0]            vld_pipe = '0;
    sample_t               in_sample;

    heading_pid UUT (
        .clk     (clk),
        .rst_n   (rst_n),
        .vld     (vld),
        .desired (desired),
        .actual  (actual),
        .steer   (steer),
        .pwr_up  (pwr_up),
        .cmd     (cmd),
        .cmd_vld (cmd_vld)
    );

    always #50 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    function automatic int clamp(input int v, input int lo, input int hi);
        return (v > hi) ? hi : (v < lo) ? lo : v;
    endfunction

    // one valid sample through error, p, d, i and the mixer
    function automatic drive_pkg::drive_cmd_t expected_cmd(input sample_t s, input int st);
        int act_v;
        int des_v;
        int e;
        int p;
        int dd;
        int sum;
        drive_pkg::drive_cmd_t c;
        act_v = $signed(s.actual);
        des_v = $signed(s.desired);
        e = clamp(act_v - des_v, -512, 511);
        // about 5/8 of the error
        p = (e >>> 1) + (e >>> 3);
        dd = clamp(e - ref_hist[ctrl_pkg::D_DEPTH-1], -64, 63);
        for (int i = ctrl_pkg::D_DEPTH - 1; i > 0; i--) begin
            ref_hist[i] = ref_hist[i-1];
        end
        ref_hist[0] = e;
        // integrator clears while powering up
        if (!s.pwr_up) begin
            ref_integ = 0;
        end else begin
            ref_integ = clamp(ref_integ + e, -32768, 32767);
        end
        sum = p + (ref_integ >>> 4) + dd * 7;
        c.lft = 12'(clamp(sum + st, -2048, 2047));
        c.rght = 12'(clamp(sum - st, -2048, 2047));
        return c;
    endfunction

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    task automatic check_cmd(input drive_pkg::drive_cmd_t got, input drive_pkg::drive_cmd_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: cmd lft %0d rght %0d, expected lft %0d rght %0d",
                     $time, got.lft, got.rght, exp.lft, exp.rght);
            $display("Verification failed");
            $fatal(1, "stopping on first error");
        end
    endtask

    task automatic check_strobe(input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch at %0t: cmd_vld %b, expected %b three cycles after vld",
                     $time, got, exp);
            $display("Verification failed");
            $fatal(1, "stopping on first error");
        end
    endtask

    // capture samples, apply the model at the edge where the mixer samples steer
    always @(posedge clk) begin
        if (rst_n) begin
            check_strobe(cmd_vld, vld_pipe[2]);
            if (vld_pipe[1]) begin
                exp_q.push_back(expected_cmd(sample_q.pop_front(), steer));
            end
            if (vld) begin
                in_sample.desired = desired;
                in_sample.actual = actual;
                in_sample.pwr_up = pwr_up;
                sample_q.push_back(in_sample);
            end
            vld_pipe <= {vld_pipe[1:0], vld};
        end
    end

    // compare process, one expected command per strobe
    always @(posedge clk) begin
        if (rst_n && cmd_vld) begin
            if (exp_q.size() == 0) begin
                $display("cmd_vld arrived with no expected command pending");
                $display("Verification failed");
                $fatal(1, "stopping on first error");
            end else begin
                check_cmd(cmd, exp_q.pop_front());
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    task automatic drive_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            vld = 1'b0;
        end
    endtask

    // actual near desired, offset drawn from off_lo up to off_lo+off_span-1
    task automatic drive_near(input int cycles, input int off_lo, input int off_span,
                              input bit rand_steer, input bit back_to_back);
        logic [31:0] rnd;
        int base;
        repeat (cycles) begin
            @(negedge clk);
            rnd = $random(seed);
            vld = back_to_back ? 1'b1 : rnd[0];
            base = $random(seed) % 16384;
            desired = 16'(base);
            actual = 16'(base + off_lo + int'({$random(seed)} % off_span));
            if (rand_steer) begin
                rnd = $random(seed);
                steer = rnd[11:0];
            end
        end
    endtask

    // fully random readings, mostly saturating
    task automatic drive_far(input int cycles, input bit rand_steer);
        logic [31:0] rnd;
        repeat (cycles) begin
            @(negedge clk);
            rnd = $random(seed);
            vld = rnd[0];
            desired = 16'($random(seed));
            actual = 16'($random(seed));
            if (rand_steer) begin
                rnd = $random(seed);
                steer = rnd[11:0];
            end
        end
    endtask

    // change pwr_up with no sample in flight on either side
    task automatic switch_power(input logic level);
        drive_idle(4);
        @(negedge clk);
        pwr_up = level;
        drive_idle(4);
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        vld = 1'b0;
        desired = '0;
        actual = '0;
        steer = '0;
        pwr_up = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        // small errors, no steer, no integral
        drive_near(60, -40, 81, 1'b0, 1'b0);
        drive_far(60, 1'b0);
        switch_power(1'b1);
        // drive the integrator into both rails
        drive_near(200, 300, 211, 1'b1, 1'b0);
        drive_near(360, -510, 211, 1'b1, 1'b0);
        drive_far(100, 1'b1);
        // samples during pwr_up low must not accumulate
        switch_power(1'b0);
        drive_near(100, -200, 401, 1'b1, 1'b0);
        switch_power(1'b1);
        // back-to-back strobes
        drive_near(60, -100, 201, 1'b0, 1'b1);
        drive_idle(10);
        if (exp_q.size() != 0 || sample_q.size() != 0) begin
            $display("outputs went missing, %0d commands never arrived",
                     exp_q.size() + sample_q.size());
            $display("Verification failed");
            $fatal(1, "missing outputs");
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

    // cycle limit
    initial begin
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Verification failed");
        $fatal(1, "run stopped by timeout");
    end

endmodule

// File: build.f
hdl/ctrl_pkg.sv
hdl/drive_pkg.sv
hdl/pd_math.sv
hdl/i_math.sv
hdl/pid_mix.sv
hdl/heading_pid.sv
bench/heading_pid_asserts.sv
bench/heading_pid_tb.sv
